// File: Bender.yml
package:
  name: noc_router

sources:
  - include_dirs:
      - logic
    files:
      - logic/noc_flit_pkg.sv
      - logic/noc_route_pkg.sv
      - logic/flit_queue.sv
      - logic/route_compute.sv
      - logic/switch_alloc.sv
      - logic/noc_router_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_checker.sv
      - testbench/tb_router.sv

// File: flist.f
+incdir+logic
logic/noc_flit_pkg.sv
logic/noc_route_pkg.sv
logic/flit_queue.sv
logic/route_compute.sv
logic/switch_alloc.sv
logic/noc_router_top.sv
testbench/tb_checker.sv
testbench/tb_router.sv

// File: logic/flit_queue.sv
`include "noc_defs.svh"

module flit_queue
    import noc_flit_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  link_t push,
    input  logic  pop,
    output link_t head
);

    localparam int DEPTH = `NOC_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage, payload only
    flit_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    // wrap at depth, works for non power of two too
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    // pop only when something is there
    assign do_pop  = pop && (count != '0);
    // full queue still takes a flit if the head leaves this cycle
    assign do_push = push.valid && (!full || do_pop);

    ////////////////////
    // pointers and count
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // write side
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push.flit;
    end

    // head visible whenever non-empty
    assign head = '{valid: (count != '0), flit: mem[rd_ptr]};

endmodule

// File: logic/noc_defs.svh
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

////////////////////
// mesh geometry
////////////////////

// bits per mesh coordinate
// 3 bits covers an 8 x 8 mesh
`define NOC_COORD_W 3

////////////////////
// flit contents
////////////////////

// data carried by one flit
`define NOC_PAYLOAD_W 64

// source tag, 2 bits origin + 6 bits sequence
// router passes it through untouched
`define NOC_TAG_W 8

////////////////////
// buffering
////////////////////

// entries per link input queue
`define NOC_QUEUE_DEPTH 4

`endif

// File: logic/noc_flit_pkg.sv
`include "noc_defs.svh"

package noc_flit_pkg;

    ////////////////////
    // flit format
    ////////////////////

    // one flit, destination in the top bits
    // dst fields are what the route unit looks at
    typedef struct packed {
        // destination column
        logic [`NOC_COORD_W-1:0]   dst_x;
        // destination row
        logic [`NOC_COORD_W-1:0]   dst_y;
        // origin and sequence, set by sender
        logic [`NOC_TAG_W-1:0]     src_tag;
        // user data
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } flit_t;

    ////////////////////
    // port format
    ////////////////////

    // links, inject and eject ports all share this
    // valid is a one-cycle strobe per flit
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

endpackage

// File: logic/noc_route_pkg.sv
package noc_route_pkg;

    // flit_t is carried inside the routed request
    import noc_flit_pkg::*;

    ////////////////////
    // directions
    ////////////////////

    // dimension-order targets of a queue head
    // eject means the flit leaves on its own input's eject port
    typedef enum logic [1:0] {
        DIR_XPOS  = 2'd0,
        DIR_YPOS  = 2'd1,
        DIR_EJECT = 2'd2
    } dir_e;

    ////////////////////
    // routed request
    ////////////////////

    // queue head plus the output it asks for
    // valid mirrors the head valid of the queue
    typedef struct packed {
        logic  valid;
        // requested output
        dir_e  dir;
        // flit as it sits at the queue head
        flit_t flit;
    } route_req_t;

endpackage

// File: logic/noc_router_top.sv
module noc_router_top
    import noc_flit_pkg::*;
    import noc_route_pkg::*;
#(
    parameter int unsigned cur_x = 0,
    parameter int unsigned cur_y = 0
) (
    input  logic  clk,
    input  logic  rst_n,
    // links from neighbours
    input  link_t in_x,
    input  link_t in_y,
    // local traffic for the link outputs
    input  link_t inject_x,
    input  link_t inject_y,
    // links to neighbours
    output link_t out_x,
    output link_t out_y,
    // local delivery, one per link input
    output link_t eject_x,
    output link_t eject_y
);

    // queue heads
    link_t      head_x;
    link_t      head_y;
    // routed heads
    route_req_t req_x;
    route_req_t req_y;
    // head taken this cycle
    logic       pop_x;
    logic       pop_y;

    ////////////////////
    // input queues
    ////////////////////
    flit_queue i_queue_x (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (in_x),
        .pop   (pop_x),
        .head  (head_x)
    );

    flit_queue i_queue_y (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (in_y),
        .pop   (pop_y),
        .head  (head_y)
    );

    ////////////////////
    // route per head
    ////////////////////
    // recomputed every cycle from whatever sits at the head
    route_compute #(.cur_x(cur_x), .cur_y(cur_y)) i_route_x (
        .head (head_x),
        .req  (req_x)
    );

    route_compute #(.cur_x(cur_x), .cur_y(cur_y)) i_route_y (
        .head (head_y),
        .req  (req_y)
    );

    ////////////////////
    // allocation and outputs
    ////////////////////
    switch_alloc i_alloc (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_x    (req_x),
        .req_y    (req_y),
        .inject_x (inject_x),
        .inject_y (inject_y),
        .pop_x    (pop_x),
        .pop_y    (pop_y),
        .out_x    (out_x),
        .out_y    (out_y),
        .eject_x  (eject_x),
        .eject_y  (eject_y)
    );

endmodule

// File: logic/route_compute.sv
`include "noc_defs.svh"

module route_compute
    import noc_flit_pkg::*;
    import noc_route_pkg::*;
#(
    parameter int unsigned cur_x = 0,
    parameter int unsigned cur_y = 0
) (
    input  link_t      head,
    output route_req_t req
);

    // node position at coordinate width
    localparam logic [`NOC_COORD_W-1:0] node_x = cur_x[`NOC_COORD_W-1:0];
    localparam logic [`NOC_COORD_W-1:0] node_y = cur_y[`NOC_COORD_W-1:0];

    dir_e route_dir;

    ////////////////////
    // dimension order
    ////////////////////
    // x first, then y, else the flit is home
    always_comb begin
        if (head.flit.dst_x != node_x) begin
            route_dir = DIR_XPOS;
        end else if (head.flit.dst_y != node_y) begin
            route_dir = DIR_YPOS;
        end else begin
            route_dir = DIR_EJECT;
        end
    end

    // flit and valid pass straight through
    assign req = '{
        valid: head.valid,
        dir:   route_dir,
        flit:  head.flit
    };

endmodule

// File: logic/switch_alloc.sv
module switch_alloc
    import noc_flit_pkg::*;
    import noc_route_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  route_req_t req_x,
    input  route_req_t req_y,
    input  link_t      inject_x,
    input  link_t      inject_y,
    output logic       pop_x,
    output logic       pop_y,
    output link_t      out_x,
    output link_t      out_y,
    output link_t      eject_x,
    output link_t      eject_y
);

    // output register slots
    localparam int SLOT_OUT_X   = 0;
    localparam int SLOT_OUT_Y   = 1;
    localparam int SLOT_EJECT_X = 2;
    localparam int SLOT_EJECT_Y = 3;
    localparam int NUM_SLOTS    = 4;

    // round robin, set means y queue wins next contest
    logic rr_favour_y;

    // head wants, xq = x input queue, yq = y input queue
    logic xq_want_x;
    logic xq_want_y;
    logic yq_want_x;
    logic yq_want_y;
    logic xq_eject;
    logic yq_eject;

    // grants per link output
    logic xq_to_out_x;
    logic yq_to_out_x;
    logic xq_to_out_y;
    logic yq_to_out_y;
    logic contest_x;
    logic contest_y;

    logic [NUM_SLOTS-1:0] nxt_valid;
    flit_t                nxt_flit [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] valid_q;
    flit_t                flit_q [NUM_SLOTS];

    // one link output, result is {grant yq, grant xq}
    // inject owns the output outright
    function automatic logic [1:0] arbitrate(
        input logic inj_valid,
        input logic want_xq,
        input logic want_yq,
        input logic favour_y
    );
        logic [1:0] gnt;
        gnt = 2'b00;
        if (!inj_valid) begin
            if (want_xq && want_yq) begin
                gnt = favour_y ? 2'b10 : 2'b01;
            end else begin
                gnt = {want_yq, want_xq};
            end
        end
        return gnt;
    endfunction

    ////////////////////
    // requests
    ////////////////////
    assign xq_want_x = req_x.valid && (req_x.dir == DIR_XPOS);
    assign xq_want_y = req_x.valid && (req_x.dir == DIR_YPOS);
    assign yq_want_x = req_y.valid && (req_y.dir == DIR_XPOS);
    assign yq_want_y = req_y.valid && (req_y.dir == DIR_YPOS);
    // eject never contends, each input has its own port
    assign xq_eject  = req_x.valid && (req_x.dir == DIR_EJECT);
    assign yq_eject  = req_y.valid && (req_y.dir == DIR_EJECT);

    assign {yq_to_out_x, xq_to_out_x} =
        arbitrate(inject_x.valid, xq_want_x, yq_want_x, rr_favour_y);
    assign {yq_to_out_y, xq_to_out_y} =
        arbitrate(inject_y.valid, xq_want_y, yq_want_y, rr_favour_y);

    // both heads on one output, no inject there
    assign contest_x = !inject_x.valid && xq_want_x && yq_want_x;
    assign contest_y = !inject_y.valid && xq_want_y && yq_want_y;

    // granted heads leave their queues at this edge
    assign pop_x = xq_eject || xq_to_out_x || xq_to_out_y;
    assign pop_y = yq_eject || yq_to_out_y || yq_to_out_x;

    ////////////////////
    // crossbar
    ////////////////////
    always_comb begin
        nxt_valid[SLOT_OUT_X] = inject_x.valid || xq_to_out_x || yq_to_out_x;
        if (inject_x.valid) begin
            nxt_flit[SLOT_OUT_X] = inject_x.flit;
        end else if (yq_to_out_x) begin
            nxt_flit[SLOT_OUT_X] = req_y.flit;
        end else begin
            nxt_flit[SLOT_OUT_X] = req_x.flit;
        end

        nxt_valid[SLOT_OUT_Y] = inject_y.valid || xq_to_out_y || yq_to_out_y;
        if (inject_y.valid) begin
            nxt_flit[SLOT_OUT_Y] = inject_y.flit;
        end else if (yq_to_out_y) begin
            nxt_flit[SLOT_OUT_Y] = req_y.flit;
        end else begin
            nxt_flit[SLOT_OUT_Y] = req_x.flit;
        end

        // ejects keep their input side
        nxt_valid[SLOT_EJECT_X] = xq_eject;
        nxt_flit[SLOT_EJECT_X]  = req_x.flit;
        nxt_valid[SLOT_EJECT_Y] = yq_eject;
        nxt_flit[SLOT_EJECT_Y]  = req_y.flit;
    end

    // strobes and pointer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q     <= '0;
            rr_favour_y <= 1'b0;
        end else begin
            valid_q <= nxt_valid;
            // at most one output can be contested per cycle
            if (contest_x || contest_y) rr_favour_y <= ~rr_favour_y;
        end
    end

    // flit data
    always_ff @(posedge clk) begin
        flit_q <= nxt_flit;
    end

    assign out_x   = '{valid: valid_q[SLOT_OUT_X],   flit: flit_q[SLOT_OUT_X]};
    assign out_y   = '{valid: valid_q[SLOT_OUT_Y],   flit: flit_q[SLOT_OUT_Y]};
    assign eject_x = '{valid: valid_q[SLOT_EJECT_X], flit: flit_q[SLOT_EJECT_X]};
    assign eject_y = '{valid: valid_q[SLOT_EJECT_Y], flit: flit_q[SLOT_EJECT_Y]};

endmodule

// File: testbench/tb_checker.sv
`include "noc_defs.svh"

module tb_checker
    import noc_flit_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input link_t out_x,
    input link_t out_y,
    input link_t eject_x,
    input link_t eject_y
);

    // port numbering, same as in tb_router
    localparam int PORT_OUT_X   = 0;
    localparam int PORT_OUT_Y   = 1;
    localparam int PORT_EJECT_X = 2;
    localparam int PORT_EJECT_Y = 3;

    // one expected flit
    // due of 0 means any arrival cycle is fine
    typedef struct packed {
        logic [1:0]  port;
        logic [1:0]  origin;
        logic [31:0] due;
        flit_t       flit;
    } expect_t;

    // all outstanding flits in sending order
    // first entry for a port and origin is the head of that stream
    expect_t     exp_q [$];
    int unsigned cyc    = 0;
    int unsigned seen   = 0;
    int unsigned errors = 0;

    ////////////////////
    // bookkeeping
    ////////////////////

    task automatic flag_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic expect_flit(input int port, input flit_t flit, input int unsigned due);
        expect_t e;
        e.port   = port[1:0];
        // origin sits in the top two tag bits
        e.origin = flit.src_tag[`NOC_TAG_W-1 -: 2];
        e.due    = due;
        e.flit   = flit;
        exp_q.push_back(e);
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    // anything still queued at the end was lost
    task automatic report_leftovers();
        expect_t e;
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            flag_error($sformatf("flit %h for port %0d from origin %0d never arrived",
                e.flit, e.port, e.origin));
        end
    endtask

    ////////////////////
    // compare one port
    ////////////////////

    task automatic check_port(input int port, input string name, input link_t lnk);
        logic [1:0] origin;
        int         idx;
        int         i;
        expect_t    e;
        if (lnk.valid !== 1'b0 && lnk.valid !== 1'b1) begin
            flag_error($sformatf("%s valid is unknown in cycle %0d", name, cyc));
        end else if (lnk.valid) begin
            seen++;
            origin = lnk.flit.src_tag[`NOC_TAG_W-1 -: 2];
            idx    = -1;
            i      = 0;
            // oldest flit of this port and origin
            while (idx < 0 && i < exp_q.size()) begin
                if (exp_q[i].port == port[1:0] && exp_q[i].origin == origin) begin
                    idx = i;
                end
                i++;
            end
            if (idx < 0) begin
                flag_error($sformatf("%s carried flit %h that no sender expected there",
                    name, lnk.flit));
            end else begin
                e = exp_q[idx];
                exp_q.delete(idx);
                if (lnk.flit !== e.flit) begin
                    $display("CHECK FAILED %s.flit expected %h got %h", name, e.flit, lnk.flit);
                    errors++;
                end
                // inject flits have a fixed arrival cycle
                if (e.due != 0 && e.due != cyc) begin
                    flag_error($sformatf("%s flit %h arrived in cycle %0d, due in cycle %0d",
                        name, lnk.flit, cyc, e.due));
                end
            end
        end
    endtask

    // sample mid-cycle, outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            check_port(PORT_OUT_X, "out_x", out_x);
            check_port(PORT_OUT_Y, "out_y", out_y);
            check_port(PORT_EJECT_X, "eject_x", eject_x);
            check_port(PORT_EJECT_Y, "eject_y", eject_y);
        end
        cyc++;
    end

endmodule

// File: testbench/tb_router.sv
`include "noc_defs.svh"

module tb_router
    import noc_flit_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_LIMIT  = 64;

    // node position of the DUT
    localparam logic [`NOC_COORD_W-1:0] NODE_X = 2;
    localparam logic [`NOC_COORD_W-1:0] NODE_Y = 3;

    // origin code, top two bits of the source tag
    localparam int ORG_IN_X  = 0;
    localparam int ORG_IN_Y  = 1;
    localparam int ORG_INJ_X = 2;
    localparam int ORG_INJ_Y = 3;

    localparam int PORT_OUT_X   = 0;
    localparam int PORT_OUT_Y   = 1;
    localparam int PORT_EJECT_X = 2;
    localparam int PORT_EJECT_Y = 3;

    // eject 8, routing 16, inject 6 + 10, contention 16, random at most 72
    localparam int MAX_FLITS = 8 + 16 + 16 + 16 + 72;

    logic   clk = 1'b0;
    logic   rst_n;
    link_t  in_x;
    link_t  in_y;
    link_t  inject_x;
    link_t  inject_y;
    link_t  out_x;
    link_t  out_y;
    link_t  eject_x;
    link_t  eject_y;

    integer seed;
    int     seq [4];
    int     tests_run;
    int     tests_failed;
    int     err_mark;
    string  cur_test;

    always #(CLK_PERIOD / 2) clk = ~clk;

    noc_router_top #(.cur_x(NODE_X), .cur_y(NODE_Y)) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_x     (in_x),
        .in_y     (in_y),
        .inject_x (inject_x),
        .inject_y (inject_y),
        .out_x    (out_x),
        .out_y    (out_y),
        .eject_x  (eject_x),
        .eject_y  (eject_y)
    );

    tb_checker i_check (
        .clk     (clk),
        .rst_n   (rst_n),
        .out_x   (out_x),
        .out_y   (out_y),
        .eject_x (eject_x),
        .eject_y (eject_y)
    );

    ////////////////////
    // reference model
    ////////////////////

    // injects own their output, link flits go x first, then y, else home
    function automatic int expected_port(input int origin, input flit_t f);
        int port;
        case (origin)
            ORG_INJ_X: port = PORT_OUT_X;
            ORG_INJ_Y: port = PORT_OUT_Y;
            default: begin
                if (f.dst_x != NODE_X) begin
                    port = PORT_OUT_X;
                end else if (f.dst_y != NODE_Y) begin
                    port = PORT_OUT_Y;
                end else begin
                    port = (origin == ORG_IN_X) ? PORT_EJECT_X : PORT_EJECT_Y;
                end
            end
        endcase
        return port;
    endfunction

    function automatic logic [`NOC_COORD_W-1:0] coord(input int v);
        return v[`NOC_COORD_W-1:0];
    endfunction

    ////////////////////
    // stimulus helpers
    ////////////////////

    // advance one edge, strobes drop unless re-driven this cycle
    task automatic next_cycle();
        @(posedge clk);
        in_x     <= '0;
        in_y     <= '0;
        inject_x <= '0;
        inject_y <= '0;
    endtask

    task automatic send_flit(input int origin, input logic [`NOC_COORD_W-1:0] dx,
                             input logic [`NOC_COORD_W-1:0] dy);
        flit_t       f;
        link_t       lnk;
        logic [31:0] seq_bits;
        int unsigned due;
        seq_bits  = seq[origin];
        f.dst_x   = dx;
        f.dst_y   = dy;
        f.src_tag = {origin[1:0], seq_bits[5:0]};
        f.payload = {$random(seed), $random(seed)};
        seq[origin]++;
        lnk.valid = 1'b1;
        lnk.flit  = f;
        case (origin)
            ORG_IN_X:  in_x <= lnk;
            ORG_IN_Y:  in_y <= lnk;
            ORG_INJ_X: inject_x <= lnk;
            default:   inject_y <= lnk;
        endcase
        // inject shows up exactly one cycle later
        due = (origin >= ORG_INJ_X) ? i_check.cyc + 1 : 0;
        i_check.expect_flit(expected_port(origin, f), f, due);
    endtask

    // skewed towards x so all three directions show up
    task automatic random_dest(output logic [`NOC_COORD_W-1:0] dx,
                               output logic [`NOC_COORD_W-1:0] dy);
        logic [31:0] r;
        r  = $random(seed);
        dx = r[2:0];
        dy = r[5:3];
        case (r[7:6])
            2'd0: begin
                dx = NODE_X;
                dy = NODE_Y;
            end
            2'd1:    dx = NODE_X;
            default: ;
        endcase
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = i_check.errors;
        tests_run++;
    endtask

    // wait for the expected streams to drain, then report
    task automatic end_test();
        int waited;
        next_cycle();
        waited = 0;
        while (i_check.outstanding() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (i_check.outstanding() != 0) begin
            i_check.flag_error($sformatf("%s: %0d flits still outstanding after %0d cycles",
                cur_test, i_check.outstanding(), DRAIN_LIMIT));
        end
        // a couple of quiet cycles catch duplicates
        repeat (2) @(posedge clk);
        if (i_check.errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, cur_test);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, cur_test, i_check.errors - err_mark);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic run_idle();
        start_test("reset_idle");
        repeat (10) next_cycle();
        if (i_check.seen != 0) begin
            i_check.flag_error("an output valid rose before any stimulus");
        end
        end_test();
    endtask

    task automatic run_eject();
        int k;
        start_test("eject");
        for (k = 0; k < 4; k++) begin
            next_cycle();
            send_flit(ORG_IN_X, NODE_X, NODE_Y);
            send_flit(ORG_IN_Y, NODE_X, NODE_Y);
        end
        end_test();
    endtask

    task automatic run_dim_order();
        int k;
        start_test("dimension_order");
        // x input to out_x, y input to out_y
        for (k = 0; k < 4; k++) begin
            next_cycle();
            send_flit(ORG_IN_X, coord(k + 3), coord($random(seed)));
            send_flit(ORG_IN_Y, NODE_X, coord(k + 4));
            next_cycle();
        end
        // and crossed over
        for (k = 0; k < 4; k++) begin
            next_cycle();
            send_flit(ORG_IN_Y, coord(k + 3), coord($random(seed)));
            send_flit(ORG_IN_X, NODE_X, coord(k + 4));
            next_cycle();
        end
        end_test();
    endtask

    task automatic run_inject();
        int k;
        start_test("inject_priority");
        // injects hold both link outputs while three link flits queue up
        for (k = 0; k < 5; k++) begin
            next_cycle();
            send_flit(ORG_INJ_X, coord($random(seed)), coord($random(seed)));
            send_flit(ORG_INJ_Y, coord($random(seed)), coord($random(seed)));
            if (k < 3) begin
                send_flit(ORG_IN_X, coord(5), NODE_Y);
                send_flit(ORG_IN_Y, NODE_X, coord(6));
            end
        end
        end_test();
    endtask

    task automatic run_contention();
        int k;
        start_test("contention");
        for (k = 0; k < 4; k++) begin
            next_cycle();
            send_flit(ORG_IN_X, coord(6), coord(k));
            send_flit(ORG_IN_Y, coord(0), coord(k + 4));
            next_cycle();
        end
        for (k = 0; k < 4; k++) begin
            next_cycle();
            send_flit(ORG_IN_X, NODE_X, coord(0));
            send_flit(ORG_IN_Y, NODE_X, coord(7));
            next_cycle();
        end
        end_test();
    endtask

    task automatic run_random();
        int                      c;
        logic [31:0]             r;
        logic [`NOC_COORD_W-1:0] dx;
        logic [`NOC_COORD_W-1:0] dy;
        start_test("random_mix");
        // links on fixed slots, injects on even cycles only
        // odd cycles keep every output free for the queues
        for (c = 0; c < 48; c++) begin
            next_cycle();
            r = $random(seed);
            if (c % 4 == 0 && r[0]) begin
                random_dest(dx, dy);
                send_flit(ORG_IN_X, dx, dy);
            end
            if (c % 4 == 2 && r[1]) begin
                random_dest(dx, dy);
                send_flit(ORG_IN_Y, dx, dy);
            end
            if (c % 2 == 0 && r[2]) begin
                send_flit(ORG_INJ_X, coord($random(seed)), coord($random(seed)));
            end
            if (c % 2 == 0 && r[3]) begin
                send_flit(ORG_INJ_Y, coord($random(seed)), coord($random(seed)));
            end
        end
        end_test();
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst_n        = 1'b0;
        in_x         = '0;
        in_y         = '0;
        inject_x     = '0;
        inject_y     = '0;
        seed         = 32'h8bac;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        foreach (seq[i]) seq[i] = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        run_idle();
        run_eject();
        run_dim_order();
        run_inject();
        run_contention();
        run_random();

        i_check.report_leftovers();
        $display("%0d tests run, %0d failed, %0d check errors",
            tests_run, tests_failed, i_check.errors);
        if (tests_failed == 0 && i_check.errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, scaled by the largest possible flit count
    initial begin
        #((MAX_FLITS * 8 + 200) * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("test failed");
        $finish;
    end

endmodule
